// ==== verilog/procPkg.sv ====
/*
 * Shared processor types: word, register index, funct code
 * Opcode and ALU operation enums, instruction field positions,
 * forwarding select codes
 */
`default_nettype none

package procPkg;

    typedef logic [15:0] word_t;
    typedef logic [2:0] regIdx_t;
    typedef logic [1:0] funct_t;

    // Anything not listed traps as illegal
    typedef enum logic [4:0] {
        OP_HALT  = 5'd0,
        OP_J     = 5'd4,
        OP_ADDI  = 5'd8,
        OP_BEQZ  = 5'd12,
        OP_BNEZ  = 5'd13,
        OP_LD    = 5'd16,
        OP_ST    = 5'd17,
        OP_RTYPE = 5'd27
    } opcode_e;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_AND
    } aluOp_e;

    // R-type function codes
    localparam funct_t FUNCT_ADD = 2'd0;
    localparam funct_t FUNCT_SUB = 2'd1;
    localparam funct_t FUNCT_XOR = 2'd2;
    localparam funct_t FUNCT_AND = 2'd3;

    // Field positions
    localparam int OPC_MSB    = 15;
    localparam int OPC_LSB    = 11;
    localparam int RS_MSB     = 10;
    localparam int RS_LSB     = 8;
    localparam int RT_MSB     = 7;
    localparam int RT_LSB     = 5;
    localparam int RDR_MSB    = 4;
    localparam int RDR_LSB    = 2;
    localparam int FUNCT_MSB  = 1;
    localparam int FUNCT_LSB  = 0;
    localparam int IMM5_MSB   = 4;
    localparam int IMM8_MSB   = 7;
    localparam int DISP11_MSB = 10;

    // Operand source selects into execute
    localparam logic [1:0] FWD_REG   = 2'd0;
    localparam logic [1:0] FWD_EXMEM = 2'd1;
    localparam logic [1:0] FWD_MEMWB = 2'd2;

endpackage

`default_nettype wire

// ==== verilog/fetch.sv ====
/*
 * Fetch stage: PC register, instruction memory with program
 * load port, stall and redirect handling, IF/ID register
 */
`timescale 1ns/1ns
`default_nettype none

module fetch #(
    parameter int IMEM_DEPTH = 256
) (
    input wire clk,
    input wire rst,
    input wire stall,
    input wire redirect,
    input wire procPkg::word_t targetPc,
    input wire progWe,
    input wire procPkg::word_t progAddr,
    input wire procPkg::word_t progData,
    output procPkg::word_t instrIfId,
    output procPkg::word_t pcIfId,
    output logic validIfId
);

    localparam int imemAw = $clog2(IMEM_DEPTH);

    procPkg::word_t instrMem [IMEM_DEPTH];
    procPkg::word_t pc;
    procPkg::word_t pcNext;

    assign pcNext = pc + 16'd1;

    // Program port is the only write path
    always_ff @(posedge clk) begin
        if (progWe) begin
            instrMem[progAddr[imemAw-1:0]] <= progData;
        end
    end

    // Redirect wins over stall and kills the slot being fetched
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
            validIfId <= 1'b0;
        end else if (redirect) begin
            pc <= targetPc;
            validIfId <= 1'b0;
        end else if (!stall) begin
            pc <= pcNext;
            validIfId <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && !redirect) begin
            instrIfId <= instrMem[pc[imemAw-1:0]];
            pcIfId <= pcNext;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/decode.sv ====
/*
 * Decode stage: opcode decode, register file with write-through,
 * immediate sign extension, ID/EX register
 */
`timescale 1ns/1ns
`default_nettype none

module decode (
    input wire clk,
    input wire rst,
    input wire procPkg::word_t instrIfId,
    input wire procPkg::word_t pcIfId,
    input wire validIfId,
    input wire stall,
    input wire redirect,
    input wire wbValid,
    input wire procPkg::regIdx_t wbReg,
    input wire procPkg::word_t wbData,
    output procPkg::word_t pcEx,
    output procPkg::word_t opA,
    output procPkg::word_t opB,
    output procPkg::word_t imm,
    output procPkg::regIdx_t rsEx,
    output procPkg::regIdx_t rtEx,
    output procPkg::regIdx_t rdEx,
    output procPkg::aluOp_e aluOp,
    output logic useImm,
    output logic isLoad,
    output logic isStore,
    output logic isBranchZ,
    output logic branchOnZero,
    output logic isJump,
    output logic regWriteEx,
    output logic illegalEx,
    output logic haltEx
);

    procPkg::word_t regFile [8];
    procPkg::opcode_e opcode;
    procPkg::funct_t funct;
    procPkg::regIdx_t rs;
    procPkg::regIdx_t rt;
    procPkg::regIdx_t rdSel;
    procPkg::word_t immSel;
    procPkg::word_t readA;
    procPkg::word_t readB;
    procPkg::aluOp_e aluSel;
    logic useImmD, loadD, storeD, branchD, onZeroD, jumpD, writeD, illegalD, haltD;
    logic bubble;

    assign opcode = procPkg::opcode_e'(instrIfId[procPkg::OPC_MSB:procPkg::OPC_LSB]);
    assign funct = instrIfId[procPkg::FUNCT_MSB:procPkg::FUNCT_LSB];
    assign rs = instrIfId[procPkg::RS_MSB:procPkg::RS_LSB];
    assign rt = instrIfId[procPkg::RT_MSB:procPkg::RT_LSB];
    assign bubble = stall || redirect || !validIfId;

    always_comb begin
        aluSel = procPkg::ALU_ADD;
        rdSel = rt;
        immSel = {{(15 - procPkg::IMM5_MSB){instrIfId[procPkg::IMM5_MSB]}},
                  instrIfId[procPkg::IMM5_MSB:0]};
        useImmD = 1'b0;
        loadD = 1'b0;
        storeD = 1'b0;
        branchD = 1'b0;
        onZeroD = 1'b0;
        jumpD = 1'b0;
        writeD = 1'b0;
        illegalD = 1'b0;
        haltD = 1'b0;
        case (opcode)
            procPkg::OP_RTYPE: begin
                writeD = 1'b1;
                rdSel = instrIfId[procPkg::RDR_MSB:procPkg::RDR_LSB];
                case (funct)
                    procPkg::FUNCT_ADD: aluSel = procPkg::ALU_ADD;
                    procPkg::FUNCT_SUB: aluSel = procPkg::ALU_SUB;
                    procPkg::FUNCT_XOR: aluSel = procPkg::ALU_XOR;
                    procPkg::FUNCT_AND: aluSel = procPkg::ALU_AND;
                    default: aluSel = procPkg::ALU_ADD;
                endcase
            end
            procPkg::OP_ADDI: begin
                writeD = 1'b1;
                useImmD = 1'b1;
            end
            procPkg::OP_LD: begin
                writeD = 1'b1;
                loadD = 1'b1;
                useImmD = 1'b1;
            end
            procPkg::OP_ST: begin
                storeD = 1'b1;
                useImmD = 1'b1;
            end
            procPkg::OP_BEQZ, procPkg::OP_BNEZ: begin
                branchD = 1'b1;
                onZeroD = (opcode == procPkg::OP_BEQZ);
                immSel = {{(15 - procPkg::IMM8_MSB){instrIfId[procPkg::IMM8_MSB]}},
                          instrIfId[procPkg::IMM8_MSB:0]};
            end
            procPkg::OP_J: begin
                jumpD = 1'b1;
                immSel = {{(15 - procPkg::DISP11_MSB){instrIfId[procPkg::DISP11_MSB]}},
                          instrIfId[procPkg::DISP11_MSB:0]};
            end
            procPkg::OP_HALT: haltD = 1'b1;
            default: illegalD = 1'b1;
        endcase
    end

    // Write-back lands before the read in the same cycle
    assign readA = (wbValid && wbReg == rs) ? wbData : regFile[rs];
    assign readB = (wbValid && wbReg == rt) ? wbData : regFile[rt];

    // All registers start at zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                regFile[i] <= '0;
            end
        end else if (wbValid) begin
            regFile[wbReg] <= wbData;
        end
    end

    always_ff @(posedge clk) begin
        pcEx <= pcIfId;
        opA <= readA;
        opB <= readB;
        imm <= immSel;
        rsEx <= rs;
        rtEx <= rt;
        rdEx <= rdSel;
        if (rst || bubble) begin
            aluOp <= procPkg::ALU_ADD;
            useImm <= 1'b0;
            isLoad <= 1'b0;
            isStore <= 1'b0;
            isBranchZ <= 1'b0;
            branchOnZero <= 1'b0;
            isJump <= 1'b0;
            regWriteEx <= 1'b0;
            illegalEx <= 1'b0;
            haltEx <= 1'b0;
        end else begin
            aluOp <= aluSel;
            useImm <= useImmD;
            isLoad <= loadD;
            isStore <= storeD;
            isBranchZ <= branchD;
            branchOnZero <= onZeroD;
            isJump <= jumpD;
            regWriteEx <= writeD;
            illegalEx <= illegalD;
            haltEx <= haltD;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/hazardUnit.sv ====
/*
 * Hazard unit: load-use stall detection and
 * operand forwarding selects for execute
 */
`timescale 1ns/1ns
`default_nettype none

module hazardUnit (
    input wire procPkg::word_t instrIfId,
    input wire validIfId,
    input wire isLoad,
    input wire regWriteEx,
    input wire procPkg::regIdx_t rdEx,
    input wire procPkg::regIdx_t rsEx,
    input wire procPkg::regIdx_t rtEx,
    input wire procPkg::regIdx_t rdMem,
    input wire regWriteMem,
    input wire isLoadMem,
    input wire procPkg::regIdx_t wbReg,
    input wire wbValid,
    output logic stall,
    output logic [1:0] fwdA,
    output logic [1:0] fwdB
);

    procPkg::opcode_e opcode;
    procPkg::regIdx_t rsId;
    procPkg::regIdx_t rtId;
    logic readsRs;
    logic readsRt;

    // EX/MEM wins over MEM/WB; loads in EX/MEM have no data yet
    function automatic logic [1:0] pickSource(input procPkg::regIdx_t src);
        if (regWriteMem && !isLoadMem && rdMem == src) begin
            return procPkg::FWD_EXMEM;
        end else if (wbValid && wbReg == src) begin
            return procPkg::FWD_MEMWB;
        end
        return procPkg::FWD_REG;
    endfunction

    assign opcode = procPkg::opcode_e'(instrIfId[procPkg::OPC_MSB:procPkg::OPC_LSB]);
    assign rsId = instrIfId[procPkg::RS_MSB:procPkg::RS_LSB];
    assign rtId = instrIfId[procPkg::RT_MSB:procPkg::RT_LSB];

    always_comb begin
        readsRs = 1'b0;
        readsRt = 1'b0;
        case (opcode)
            procPkg::OP_RTYPE, procPkg::OP_ST: begin
                readsRs = 1'b1;
                readsRt = 1'b1;
            end
            procPkg::OP_ADDI, procPkg::OP_LD, procPkg::OP_BEQZ, procPkg::OP_BNEZ: begin
                readsRs = 1'b1;
            end
            default: ;
        endcase
    end

    assign stall = validIfId && isLoad && regWriteEx &&
                   ((readsRs && rdEx == rsId) || (readsRt && rdEx == rtId));

    assign fwdA = pickSource(rsEx);
    assign fwdB = pickSource(rtEx);

endmodule

`default_nettype wire

// ==== verilog/execute.sv ====
/*
 * Execute stage: operand forwarding, ALU, branch and jump
 * resolution, EX/MEM register
 */
`timescale 1ns/1ns
`default_nettype none

module execute (
    input wire clk,
    input wire rst,
    input wire procPkg::word_t pcEx,
    input wire procPkg::word_t opA,
    input wire procPkg::word_t opB,
    input wire procPkg::word_t imm,
    input wire procPkg::regIdx_t rdEx,
    input wire procPkg::aluOp_e aluOp,
    input wire useImm,
    input wire isLoad,
    input wire isStore,
    input wire isBranchZ,
    input wire branchOnZero,
    input wire isJump,
    input wire regWriteEx,
    input wire illegalEx,
    input wire haltEx,
    input wire [1:0] fwdA,
    input wire [1:0] fwdB,
    input wire procPkg::word_t wbData,
    output procPkg::word_t aluResMem,
    output procPkg::word_t storeDataMem,
    output procPkg::regIdx_t rdMem,
    output logic regWriteMem,
    output logic isLoadMem,
    output logic isStoreMem,
    output logic illegalMem,
    output logic haltMem,
    output logic redirect,
    output procPkg::word_t targetPc
);

    procPkg::word_t srcA;
    procPkg::word_t srcB;
    procPkg::word_t aluB;
    procPkg::word_t aluRes;
    logic taken;
    logic draining;

    function automatic procPkg::word_t pickOperand(input logic [1:0] sel,
                                                   input procPkg::word_t regVal);
        case (sel)
            procPkg::FWD_EXMEM: return aluResMem;
            procPkg::FWD_MEMWB: return wbData;
            default: return regVal;
        endcase
    endfunction

    assign srcA = pickOperand(fwdA, opA);
    assign srcB = pickOperand(fwdB, opB);
    assign aluB = useImm ? imm : srcB;

    always_comb begin
        case (aluOp)
            procPkg::ALU_SUB: aluRes = srcA - aluB;
            procPkg::ALU_XOR: aluRes = srcA ^ aluB;
            procPkg::ALU_AND: aluRes = srcA & aluB;
            default: aluRes = srcA + aluB;
        endcase
    end

    // pcEx already holds PC + 1
    assign taken = isJump || (isBranchZ && ((srcA == '0) == branchOnZero));
    assign redirect = taken && !draining;
    assign targetPc = pcEx + imm;

    // Everything younger than a halt or trap is squashed
    always_ff @(posedge clk) begin
        if (rst) begin
            draining <= 1'b0;
        end else if (haltEx || illegalEx) begin
            draining <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        aluResMem <= aluRes;
        storeDataMem <= srcB;
        rdMem <= rdEx;
        if (rst || draining) begin
            regWriteMem <= 1'b0;
            isLoadMem <= 1'b0;
            isStoreMem <= 1'b0;
            illegalMem <= 1'b0;
            haltMem <= 1'b0;
        end else begin
            regWriteMem <= regWriteEx;
            isLoadMem <= isLoad;
            isStoreMem <= isStore;
            illegalMem <= illegalEx;
            haltMem <= haltEx;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/dmemory.sv ====
/*
 * Memory stage: data memory, MEM/WB register,
 * halted and err flags
 */
`timescale 1ns/1ns
`default_nettype none

module dmemory #(
    parameter int DMEM_DEPTH = 256
) (
    input wire clk,
    input wire rst,
    input wire procPkg::word_t aluResMem,
    input wire procPkg::word_t storeDataMem,
    input wire procPkg::regIdx_t rdMem,
    input wire regWriteMem,
    input wire isLoadMem,
    input wire isStoreMem,
    input wire illegalMem,
    input wire haltMem,
    output logic wbValid,
    output procPkg::regIdx_t wbReg,
    output procPkg::word_t wbData,
    output logic halted,
    output logic err
);

    localparam int dmemAw = $clog2(DMEM_DEPTH);

    procPkg::word_t dataMem [DMEM_DEPTH];
    logic [dmemAw-1:0] addr;

    assign addr = aluResMem[dmemAw-1:0];

    always_ff @(posedge clk) begin
        if (isStoreMem) begin
            dataMem[addr] <= storeDataMem;
        end
    end

    // Write-back select happens here, decode sees the final value
    always_ff @(posedge clk) begin
        wbReg <= rdMem;
        wbData <= isLoadMem ? dataMem[addr] : aluResMem;
        if (rst) begin
            wbValid <= 1'b0;
            halted <= 1'b0;
            err <= 1'b0;
        end else begin
            wbValid <= regWriteMem && !halted;
            halted <= halted || haltMem || illegalMem;
            err <= err || illegalMem;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/proc.sv ====
/*
 * Processor top level: five-stage pipeline built from the
 * fetch, decode, hazard, execute and memory stages
 */
`timescale 1ns/1ns
`default_nettype none

module proc #(
    parameter int IMEM_DEPTH = 256,
    parameter int DMEM_DEPTH = 256
) (
    input wire clk,
    input wire rst,
    input wire progWe,
    input wire procPkg::word_t progAddr,
    input wire procPkg::word_t progData,
    output logic wbValid,
    output procPkg::regIdx_t wbReg,
    output procPkg::word_t wbData,
    output logic halted,
    output logic err
);

    // IF/ID
    procPkg::word_t instrIfId, pcIfId;
    logic validIfId;

    // ID/EX
    procPkg::word_t pcEx, opA, opB, imm;
    procPkg::regIdx_t rsEx, rtEx, rdEx;
    procPkg::aluOp_e aluOp;
    logic useImm, isLoad, isStore, isBranchZ, branchOnZero, isJump;
    logic regWriteEx, illegalEx, haltEx;

    // EX/MEM
    procPkg::word_t aluResMem, storeDataMem;
    procPkg::regIdx_t rdMem;
    logic regWriteMem, isLoadMem, isStoreMem, illegalMem, haltMem;

    // Hazard and redirect
    logic stall, redirect;
    logic [1:0] fwdA, fwdB;
    procPkg::word_t targetPc;

    fetch #(.IMEM_DEPTH(IMEM_DEPTH)) fetch0 (
        .clk(clk), .rst(rst), .stall(stall), .redirect(redirect), .targetPc(targetPc),
        .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .instrIfId(instrIfId), .pcIfId(pcIfId), .validIfId(validIfId)
    );

    decode decode0 (
        .clk(clk), .rst(rst), .instrIfId(instrIfId), .pcIfId(pcIfId),
        .validIfId(validIfId), .stall(stall), .redirect(redirect),
        .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
        .pcEx(pcEx), .opA(opA), .opB(opB), .imm(imm),
        .rsEx(rsEx), .rtEx(rtEx), .rdEx(rdEx), .aluOp(aluOp),
        .useImm(useImm), .isLoad(isLoad), .isStore(isStore), .isBranchZ(isBranchZ),
        .branchOnZero(branchOnZero), .isJump(isJump), .regWriteEx(regWriteEx),
        .illegalEx(illegalEx), .haltEx(haltEx)
    );

    hazardUnit hazard0 (
        .instrIfId(instrIfId), .validIfId(validIfId), .isLoad(isLoad),
        .regWriteEx(regWriteEx), .rdEx(rdEx), .rsEx(rsEx), .rtEx(rtEx),
        .rdMem(rdMem), .regWriteMem(regWriteMem), .isLoadMem(isLoadMem),
        .wbReg(wbReg), .wbValid(wbValid),
        .stall(stall), .fwdA(fwdA), .fwdB(fwdB)
    );

    execute exec0 (
        .clk(clk), .rst(rst), .pcEx(pcEx), .opA(opA), .opB(opB), .imm(imm),
        .rdEx(rdEx), .aluOp(aluOp), .useImm(useImm), .isLoad(isLoad),
        .isStore(isStore), .isBranchZ(isBranchZ), .branchOnZero(branchOnZero),
        .isJump(isJump), .regWriteEx(regWriteEx), .illegalEx(illegalEx),
        .haltEx(haltEx), .fwdA(fwdA), .fwdB(fwdB), .wbData(wbData),
        .aluResMem(aluResMem), .storeDataMem(storeDataMem), .rdMem(rdMem),
        .regWriteMem(regWriteMem), .isLoadMem(isLoadMem), .isStoreMem(isStoreMem),
        .illegalMem(illegalMem), .haltMem(haltMem),
        .redirect(redirect), .targetPc(targetPc)
    );

    dmemory #(.DMEM_DEPTH(DMEM_DEPTH)) memory0 (
        .clk(clk), .rst(rst), .aluResMem(aluResMem), .storeDataMem(storeDataMem),
        .rdMem(rdMem), .regWriteMem(regWriteMem), .isLoadMem(isLoadMem),
        .isStoreMem(isStoreMem), .illegalMem(illegalMem), .haltMem(haltMem),
        .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
        .halted(halted), .err(err)
    );

endmodule

`default_nettype wire

// ==== bench/procChk.sv ====
/*
 * Bound checker for the processor top level:
 * reset values and halt/err flag invariants
 */
`timescale 1ns/1ns
`default_nettype none

module procChk (
    input wire clk,
    input wire rst,
    input wire wbValid,
    input wire halted,
    input wire err
);

    // Flags come out of reset clear
    resetClear: assert property (@(posedge clk) $fell(rst) |-> !halted && !err)
        else $error("halted or err set in the first cycle after reset");

    errHalts: assert property (@(posedge clk) disable iff (rst) err |-> halted)
        else $error("err raised without halted");

    quietAfterHalt: assert property (@(posedge clk) disable iff (rst) halted |-> !wbValid)
        else $error("write-back seen after halt");

    // Sticky until the next reset
    haltSticky: assert property (@(posedge clk) disable iff (rst) $past(halted) |-> halted)
        else $error("halted fell while out of reset");

endmodule

bind proc procChk chk0 (
    .clk(clk),
    .rst(rst),
    .wbValid(wbValid),
    .halted(halted),
    .err(err)
);

`default_nettype wire

// ==== bench/procTb.sv ====
/*
 * Testbench for the pipelined processor: clock and reset,
 * program loading from the case file, write-back trace checks
 */
`timescale 1ns/1ns
`default_nettype none

module procTb;

    localparam int RESET_CYCLES = 16;
    localparam int WAIT_LIMIT = 64;
    localparam int QUIET_CYCLES = 8;

    logic clk = 1'b0;
    logic rst;
    logic progWe;
    procPkg::word_t progAddr;
    procPkg::word_t progData;
    logic wbValid;
    procPkg::regIdx_t wbReg;
    procPkg::word_t wbData;
    logic halted;
    logic err;

    // Case being assembled from the file
    string caseName;
    procPkg::word_t progQ[$];
    procPkg::regIdx_t expRegQ[$];
    procPkg::word_t expDataQ[$];
    logic expErr;

    int mismatches = 0;
    int timeouts = 0;
    int setupErrors = 0;
    int casesRun = 0;

    proc #(
        .IMEM_DEPTH(256),
        .DMEM_DEPTH(256)
    ) i_dut (
        .clk(clk), .rst(rst), .progWe(progWe), .progAddr(progAddr), .progData(progData),
        .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData), .halted(halted), .err(err)
    );

    always #2 clk = ~clk;

    task automatic checkReg(input string what, input procPkg::regIdx_t expected,
                            input procPkg::regIdx_t actual);
        if (actual !== expected) begin
            $display("Fail %s %s: expected r%0d, got r%0d", caseName, what, expected, actual);
            mismatches++;
        end
    endtask

    task automatic checkWord(input string what, input procPkg::word_t expected,
                             input procPkg::word_t actual);
        if (actual !== expected) begin
            $display("Fail %s %s: expected %h, got %h", caseName, what, expected, actual);
            mismatches++;
        end
    endtask

    task automatic checkFlag(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Fail %s %s: expected %b, got %b", caseName, what, expected, actual);
            mismatches++;
        end
    endtask

    task automatic reportExtra();
        if (wbValid === 1'b1) begin
            $display("Case %s wrote back r%0d = %h where no write-back was expected",
                     caseName, wbReg, wbData);
            mismatches++;
        end
    endtask

    // Program is written while rst is held for at least 16 cycles
    task automatic loadProgram();
        int cycles;
        int i;
        cycles = (progQ.size() > RESET_CYCLES) ? progQ.size() : RESET_CYCLES;
        @(posedge clk);
        rst <= 1'b1;
        for (i = 0; i < cycles; i++) begin
            @(posedge clk);
            if (i < progQ.size()) begin
                progWe <= 1'b1;
                progAddr <= procPkg::word_t'(i);
                progData <= progQ[i];
            end else begin
                progWe <= 1'b0;
            end
        end
        @(posedge clk);
        progWe <= 1'b0;
        rst <= 1'b0;
    endtask

    // Outputs sampled on the falling edge away from register updates
    task automatic awaitWriteBack(output logic seen);
        int cycles;
        seen = 1'b0;
        cycles = 0;
        while (!seen && halted !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            seen = (wbValid === 1'b1);
            cycles++;
        end
    endtask

    task automatic runCase();
        logic seen;
        int idx;
        int cycles;
        logic aborted;
        loadProgram();
        aborted = 1'b0;
        for (idx = 0; idx < expRegQ.size() && !aborted; idx++) begin
            awaitWriteBack(seen);
            if (seen) begin
                checkReg($sformatf("wbReg[%0d]", idx), expRegQ[idx], wbReg);
                checkWord($sformatf("wbData[%0d]", idx), expDataQ[idx], wbData);
            end else if (halted === 1'b1) begin
                $display("Case %s halted before write-back %0d", caseName, idx);
                mismatches++;
                aborted = 1'b1;
            end else begin
                $display("Timeout in case %s waiting for write-back %0d", caseName, idx);
                timeouts++;
                aborted = 1'b1;
            end
        end
        // Any write-back after the full trace is extra
        cycles = 0;
        while (halted !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            reportExtra();
            cycles++;
        end
        if (halted !== 1'b1) begin
            $display("Timeout in case %s waiting for halted", caseName);
            timeouts++;
        end
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            reportExtra();
        end
        checkFlag("halted", 1'b1, halted);
        checkFlag("err", expErr, err);
        casesRun++;
    endtask

    task automatic parseLine(input string line);
        string tag;
        string name;
        logic [31:0] a;
        logic [31:0] b;
        int n;
        tag = "";
        n = $sscanf(line, "%s", tag);
        if (n < 1 || tag.substr(0, 0) == "#") begin
            return;
        end
        if (tag == "case") begin
            n = $sscanf(line, "%s %s", tag, name);
            caseName = name;
            progQ.delete();
            expRegQ.delete();
            expDataQ.delete();
            expErr = 1'b0;
        end else if (tag == "prog") begin
            n = $sscanf(line, "%s %h", tag, a);
            progQ.push_back(a[15:0]);
        end else if (tag == "wb") begin
            n = $sscanf(line, "%s %d %h", tag, a, b);
            expRegQ.push_back(a[2:0]);
            expDataQ.push_back(b[15:0]);
        end else if (tag == "err") begin
            n = $sscanf(line, "%s %d", tag, a);
            expErr = a[0];
        end else if (tag == "end") begin
            runCase();
        end else begin
            $display("Unknown line in case file: %s", line);
            setupErrors++;
        end
    endtask

    initial begin
        int fd;
        int rc;
        string line;
        rst = 1'b1;
        progWe = 1'b0;
        progAddr = '0;
        progData = '0;
        fd = $fopen("bench/procCases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file bench/procCases.txt");
            setupErrors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                rc = $fgets(line, fd);
                if (rc > 0) begin
                    parseLine(line);
                end
            end
            $fclose(fd);
        end
        if (casesRun == 0) begin
            $display("No test case was run");
            setupErrors++;
        end
        $display("Errors: %0d mismatches, %0d timeouts, %0d setup problems over %0d cases",
                 mismatches, timeouts, setupErrors, casesRun);
        if (mismatches + timeouts + setupErrors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/procCases.txt ====
# Lines: case <name> | prog <hex instruction> | wb <reg> <hex value> | err <0|1> | end
# Program words load from address 0; wb lines give the write-back trace in order
case aluChain
prog 4025
prog 4143
prog 427E
prog DB50
prog DC35
prog DD9A
prog DEBF
prog D941
prog 0000
wb 1 0005
wb 2 0008
wb 3 0006
wb 4 000E
wb 5 0009
wb 6 0007
wb 7 0001
wb 0 FFFD
err 0
end
case storeLoad
prog 402A
prog 4047
prog 8A21
prog 8261
prog DB30
prog 0000
wb 1 000A
wb 2 0007
wb 3 000A
wb 4 0014
err 0
end
case branches
prog 4020
prog 6102
prog 4041
prog 4042
prog 4063
prog 2002
prog 4084
prog 4085
prog 6903
prog 43A6
prog 0000
wb 1 0000
wb 3 0003
wb 5 0009
err 0
end
case illegal
prog 4029
prog 4141
prog F800
prog 4061
prog 0000
wb 1 0009
wb 2 000A
err 1
end

// ==== build.f ====
verilog/procPkg.sv
verilog/fetch.sv
verilog/decode.sv
verilog/hazardUnit.sv
verilog/execute.sv
verilog/dmemory.sv
verilog/proc.sv
bench/procChk.sv
bench/procTb.sv
